//--- src/rom_fetch_config.svh
`ifndef ROM_FETCH_CONFIG_SVH
`define ROM_FETCH_CONFIG_SVH

//////////////////////////////
// ROM read path widths
//////////////////////////////

// Byte address width seen by the requester
`define ROM_AW 18

// Width of one word returned by the external ROM
`define ROM_WW 32

// Width of one requester access with four lanes per ROM word
`define ROM_DW 8

// Set to 1 to swap the two bytes of each half word on the read side
`define ROM_INVERT_A0 0

`endif

//--- src/rom_fetch_pkg.sv
`include "rom_fetch_config.svh"

package rom_fetch_pkg;

    //////////////////////////////
    // Data widths
    //////////////////////////////

    typedef logic [`ROM_AW-1:0] rom_addr_t;
    typedef logic [`ROM_WW-1:0] rom_word_t;
    typedef logic [`ROM_DW-1:0] rom_byte_t;

    // External ROM read request with a word aligned addr
    typedef struct packed {
        logic      rd;
        rom_addr_t addr;
    } rom_rd_t;

    // Fill write back into the cache
    typedef struct packed {
        logic      we;
        rom_word_t data;
    } rom_fill_t;

    // Fetch controller states
    typedef enum logic [1:0] {
        fetch_idle = 2'd0,
        fetch_wait = 2'd1,
        fetch_fill = 2'd2
    } fetch_state_t;
endpackage

//--- src/rom_req_cache.sv
`timescale 1ns/1ps
`include "rom_fetch_config.svh"

module rom_req_cache (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cen,
    input  rom_fetch_pkg::rom_addr_t addr,
    input  logic                     addr_ok,
    input  rom_fetch_pkg::rom_fill_t fill,
    output logic                     miss_req,
    output rom_fetch_pkg::rom_addr_t word_addr,
    output rom_fetch_pkg::rom_byte_t dout
);

    //////////////////////////////
    // Storage and control state
    //////////////////////////////

    // Tag and word of entry 0
    rom_fetch_pkg::rom_addr_t tag0;
    rom_fetch_pkg::rom_word_t data0;

    // Tag and word of entry 1
    rom_fetch_pkg::rom_addr_t tag1;
    rom_fetch_pkg::rom_word_t data1;

    // High from reset until the first fill has loaded both entries
    logic init;

    // Picks the entry that the next fill overwrites
    logic repl_sel;

    // Per-entry tag match against the current word address
    logic hit0;
    logic hit1;

    // A fill is only accepted on a clock enable cycle
    logic fill_take;

    // Word of the matching entry and the byte lane inside it
    rom_fetch_pkg::rom_word_t data_mux;
    logic [1:0]               lane;

    //////////////////////////////
    // Address compare
    //////////////////////////////

    // With four byte lanes per word the two low bits never take part in the tag
    assign word_addr = {addr[`ROM_AW-1:2], 2'b00};

    assign hit0 = (word_addr == tag0);
    assign hit1 = (word_addr == tag1);

    // Tags hold garbage before the first fill, so init forces a request
    // Without addr_ok the address is not meaningful and no request is raised
    assign miss_req = init || (!(hit0 || hit1) && addr_ok);

    assign fill_take = cen && fill.we;

    //////////////////////////////
    // Replacement control
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            init     <= 1'b1;
            repl_sel <= 1'b0;
        end else if (fill_take) begin
            init <= 1'b0;
            // The first fill lands in both entries and does not count for replacement
            if (!init) begin
                repl_sel <= ~repl_sel;
            end
        end
    end

    // The first fill after reset writes both entries and later fills follow repl_sel
    always_ff @(posedge clk) begin
        if (fill_take) begin
            if (init || !repl_sel) begin
                tag0  <= word_addr;
                data0 <= fill.data;
            end
            if (init || repl_sel) begin
                tag1  <= word_addr;
                data1 <= fill.data;
            end
        end
    end

    //////////////////////////////
    // Byte select
    //////////////////////////////

    // Entry 1 is selected whenever entry 0 does not match
    assign data_mux = hit0 ? data0 : data1;

    // Bit 0 inverted swaps bytes within each half word
    assign lane[1] = addr[1];
    assign lane[0] = (`ROM_INVERT_A0 != 0) ? ~addr[0] : addr[0];

    // The byte is captured on every clock without a pending miss
    // so it is valid one clock after busy falls or after a hit address settles
    always_ff @(posedge clk) begin
        if (!miss_req) begin
            dout <= data_mux[lane*`ROM_DW +: `ROM_DW];
        end
    end

endmodule

//--- src/rom_fetch_ctrl.sv
`timescale 1ns/1ps
`include "rom_fetch_config.svh"

module rom_fetch_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cen,
    input  logic                     miss_req,
    input  rom_fetch_pkg::rom_addr_t word_addr,
    input  rom_fetch_pkg::rom_word_t rom_data,
    input  logic                     rom_ok,
    output rom_fetch_pkg::rom_rd_t   rom_rd,
    output rom_fetch_pkg::rom_fill_t fill
);

    //////////////////////////////
    // Fetch state
    //////////////////////////////

    rom_fetch_pkg::fetch_state_t state;

    // Read strobe that is high for exactly one clock per miss
    logic rd_q;

    // Address of the outstanding read
    rom_fetch_pkg::rom_addr_t addr_q;

    // Word returned by the ROM and held until the cache takes it
    rom_fetch_pkg::rom_word_t data_q;

    // Conditions that start a read and end the wait
    logic issue;
    logic capture;

    // A new read only starts from idle on a clock enable cycle
    assign issue   = (state == rom_fetch_pkg::fetch_idle) && cen && miss_req;
    assign capture = (state == rom_fetch_pkg::fetch_wait) && rom_ok;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= rom_fetch_pkg::fetch_idle;
            rd_q  <= 1'b0;
        end else begin
            // Strobe defaults low so it never lasts more than one clock
            rd_q <= 1'b0;
            case (state)
                rom_fetch_pkg::fetch_idle: begin
                    if (issue) begin
                        rd_q  <= 1'b1;
                        state <= rom_fetch_pkg::fetch_wait;
                    end
                end
                rom_fetch_pkg::fetch_wait: begin
                    // ROM latency varies and rom_ok alone ends the wait
                    if (capture) begin
                        state <= rom_fetch_pkg::fetch_fill;
                    end
                end
                rom_fetch_pkg::fetch_fill: begin
                    // The cache writes on this cen cycle, so the miss clears next clock
                    if (cen) begin
                        state <= rom_fetch_pkg::fetch_idle;
                    end
                end
                default: begin
                    state <= rom_fetch_pkg::fetch_idle;
                end
            endcase
        end
    end

    //////////////////////////////
    // Read address and fill word
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (issue) begin
            addr_q <= word_addr;
        end
        if (capture) begin
            data_q <= rom_data;
        end
    end

    assign rom_rd.rd   = rd_q;
    assign rom_rd.addr = addr_q;

    // Write enable stays up for the whole fill state and the cache qualifies it with cen
    assign fill.we   = (state == rom_fetch_pkg::fetch_fill);
    assign fill.data = data_q;

endmodule

//--- src/rom_fetch_top.sv
`timescale 1ns/1ps
`include "rom_fetch_config.svh"

module rom_fetch_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cen,
    input  rom_fetch_pkg::rom_addr_t addr,
    input  logic                     addr_ok,
    input  rom_fetch_pkg::rom_word_t rom_data,
    input  logic                     rom_ok,
    output rom_fetch_pkg::rom_byte_t dout,
    output logic                     busy,
    output rom_fetch_pkg::rom_rd_t   rom_rd
);

    //////////////////////////////
    // Stage links
    //////////////////////////////

    // Word aligned address of the current access that is copied into the ROM read
    rom_fetch_pkg::rom_addr_t word_addr;

    // Fill path running back from the fetch stage into the cache
    rom_fetch_pkg::rom_fill_t fill;

    // Stage 1 compares the address and selects the byte
    // Its miss request is the busy flag seen by the requester
    rom_req_cache u_cache (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen       (cen),
        .addr      (addr),
        .addr_ok   (addr_ok),
        .fill      (fill),
        .miss_req  (busy),
        .word_addr (word_addr),
        .dout      (dout)
    );

    // Stage 2 reads the missing word from the ROM and writes it back
    rom_fetch_ctrl u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen       (cen),
        .miss_req  (busy),
        .word_addr (word_addr),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .rom_rd    (rom_rd),
        .fill      (fill)
    );

endmodule

//--- verification/tb_rom_fetch.sv
`timescale 1ns/1ps
`include "rom_fetch_config.svh"

module tb_rom_fetch;

    //////////////////////////////
    // Constants and signals
    //////////////////////////////

    localparam int CLK_PERIOD = 8;

    // Access entries start at this index of the stimulus memory
    localparam int ACC_BASE   = 32;
    localparam int STIM_DEPTH = 128;

    // Clock and the ROM side inputs start low through their declarations
    logic                     clk      = 1'b0;
    logic                     cen      = 1'b0;
    logic                     rom_ok   = 1'b0;
    rom_fetch_pkg::rom_word_t rom_data = '0;

    logic                     rst_n;
    rom_fetch_pkg::rom_addr_t addr;
    logic                     addr_ok;
    rom_fetch_pkg::rom_byte_t dout;
    logic                     busy;

    // External read request with its strobe and word address
    rom_fetch_pkg::rom_rd_t   rom_rd;

    // ROM image in words 0 to 15 and the access list from ACC_BASE on
    logic [31:0] stim_mem [0:STIM_DEPTH-1];

    int n_access = 0;
    int rd_total = 0;
    int fetch_total;

    // Word address that the current access should fetch
    rom_fetch_pkg::rom_addr_t cur_word;

    // ROM model state for the single outstanding read
    logic                     rom_pending = 1'b0;
    int                       rom_wait    = 0;
    rom_fetch_pkg::rom_addr_t rom_addr_q;

    rom_fetch_top u_rom_fetch_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen      (cen),
        .addr     (addr),
        .addr_ok  (addr_ok),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .dout     (dout),
        .busy     (busy),
        .rom_rd   (rom_rd)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////
    // Error handling
    //////////////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "stopped on first mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("Error at %0d ns: %s", $time, reason);
        $display("Simulation failed");
        $fatal(1, "stopped on error");
    endtask

    //////////////////////////////
    // ROM model and clock enable
    //////////////////////////////

    // Everything here changes on the falling edge away from the DUT's rising edge
    always @(negedge clk) begin
        cen    <= ($urandom % 2 == 0);
        rom_ok <= 1'b0;
        if (rst_n && rom_rd.rd) begin
            rd_total++;
            if (rom_pending) begin
                abort_run("rom_rd strobe while a ROM read is still outstanding");
            end
            if (rom_rd.addr !== cur_word) begin
                abort_run("rom_rd address is not the word address of the current access");
            end
            if (rom_rd.addr[`ROM_AW-1:6] != '0) begin
                abort_run("rom_rd address lies outside the ROM image");
            end
            rom_pending = 1'b1;
            rom_addr_q  = rom_rd.addr;
            // Zero answers on the next clock and three answers four clocks later
            rom_wait    = $urandom % 4;
        end else if (rom_pending) begin
            rom_wait--;
        end
        if (rom_pending && rom_wait == 0) begin
            rom_ok      <= 1'b1;
            rom_data    <= stim_mem[rom_addr_q[5:2]];
            rom_pending = 1'b0;
        end
    end

    //////////////////////////////
    // Requester
    //////////////////////////////

    // Entry layout is {flags, expected byte, byte address}
    // Flag bit 30 asks for a dout check, bit 29 is addr_ok, bit 28 marks a fetch
    task automatic apply_access(input int idx, output int rd_start);
        logic [31:0] entry;
        entry    = stim_mem[ACC_BASE + idx];
        addr     <= entry[`ROM_AW-1:0];
        addr_ok  <= entry[29];
        cur_word = {entry[`ROM_AW-1:2], 2'b00};
        rd_start = rd_total;
    endtask

    // Waits out the miss and checks at the clock after busy falls
    task automatic finish_access(input int idx, input int rd_start);
        logic [31:0] entry;
        entry = stim_mem[ACC_BASE + idx];
        @(negedge clk);
        // A hit or an access without addr_ok must never raise busy
        if (!entry[28]) begin
            check_value("busy", 32'(busy), 32'h0);
        end
        while (busy) begin
            @(negedge clk);
        end
        @(negedge clk);
        check_value("busy", 32'(busy), 32'h0);
        check_value("rom_rd strobes", 32'(rd_total - rd_start), 32'(entry[28]));
        if (entry[30]) begin
            check_value("dout", 32'(dout), 32'(entry[27:20]));
        end
    endtask

    initial begin
        int count;
        int rd_start;
        void'($urandom(32'h4e52));
        rst_n       = 1'b0;
        addr        = '0;
        addr_ok     = 1'b0;
        cur_word    = '0;
        fetch_total = 0;
        count       = 0;
        $readmemh("verification/rom_stimulus.txt", stim_mem);

        // The list ends at the first all ones entry and flag bit 28 counts the fetches
        while (ACC_BASE + count < STIM_DEPTH
               && stim_mem[ACC_BASE + count] !== 32'hffff_ffff) begin
            if (stim_mem[ACC_BASE + count][28]) begin
                fetch_total++;
            end
            count++;
        end
        if (count == 0 || ACC_BASE + count == STIM_DEPTH) begin
            abort_run("stimulus file holds no terminated access list");
        end
        n_access = count;

        // The first address is in place before reset ends, since init fetches at once
        repeat (3) @(negedge clk);
        apply_access(0, rd_start);
        @(negedge clk);
        check_value("busy", 32'(busy), 32'h1);
        rst_n <= 1'b1;

        for (int i = 0; i < n_access; i++) begin
            if (i > 0) begin
                apply_access(i, rd_start);
            end
            finish_access(i, rd_start);
        end

        // No stray read may follow the last access
        repeat (4) @(negedge clk);
        check_value("rom_rd total", 32'(rd_total), 32'(fetch_total));
        $display("Simulation completed successfully");
        $finish;
    end

    // Forty clocks per access cover the worst ROM latency with sparse cen
    initial begin
        wait (n_access != 0);
        repeat (n_access * 40 + 8) @(posedge clk);
        abort_run("timeout, the access list did not complete");
    end

endmodule

//--- verification/rom_stimulus.txt
// Words 00-0f: ROM image, word k holds bytes 40+4k to 43+4k, lane 0 in the low byte
// From 20: access {flags, expected byte, byte address}, flags 4 check dout, 2 addr_ok, 1 fetch
@00
43424140 47464544 4b4a4948 4f4e4d4c
53525150 57565554 5b5a5958 5f5e5d5c
63626160 67666564 6b6a6968 6f6e6d6c
73727170 77767574 7b7a7978 7f7e7d7c
@20
7_45_00005 // first access after reset loads both entries
6_44_00004
6_46_00006
6_47_00007
6_45_00005
7_50_00010 // second word goes to entry 0
6_46_00006
6_53_00013
6_44_00004
6_51_00011
7_60_00020 // third word evicts entry 1
6_52_00012
7_45_00005
6_62_00022
7_70_00030
7_61_00021
6_73_00033
0_00_00008 // addr_ok low on a missing word
0_00_0003c
4_63_00023 // addr_ok low on a stored word
7_49_00009
6_4b_0000b
7_7e_0003e
6_4a_0000a
6_7d_0003d
7_5c_0001c
6_7f_0003f
6_5f_0001f
ffffffff

//--- flist.f
+incdir+src
src/rom_fetch_pkg.sv
src/rom_req_cache.sv
src/rom_fetch_ctrl.sv
src/rom_fetch_top.sv
verification/tb_rom_fetch.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --timing -f flist.f --top-module tb_rom_fetch -o sim_rom_fetch 2>&1 \
    && ./obj_dir/sim_rom_fetch 2>&1)
echo "$out"
echo "$out" | grep -qx "Simulation completed successfully" && exit 0 || exit 1
